// ==== logic/mipsPkg.sv ====
package mipsPkg;

  typedef logic [31:0] wordT;     // data or instruction word
  typedef logic [4:0]  regAddrT;  // register number
  typedef logic [31:0] addrT;     // byte address, pc side

  localparam regAddrT zeroReg = 5'd0;  // hardwired zero
  localparam int dmemWords = 64;       // data memory depth in words

  // primary opcodes, instr[31:26]
  localparam logic [5:0] opRtype = 6'h00;
  localparam logic [5:0] opLw    = 6'h23;
  localparam logic [5:0] opSw    = 6'h2b;
  localparam logic [5:0] opBeq   = 6'h04;
  localparam logic [5:0] opAddiu = 6'h09;

  // r-type funct, instr[5:0]
  localparam logic [5:0] fnAddu = 6'h21;
  localparam logic [5:0] fnSubu = 6'h23;
  localparam logic [5:0] fnAnd  = 6'h24;
  localparam logic [5:0] fnOr   = 6'h25;
  localparam logic [5:0] fnSlt  = 6'h2a;

  typedef enum logic [2:0] {ADD, SUB, AND, OR, SLT} aluOpT;  // ADD is zero so a bubble adds
  typedef enum logic [1:0] {fwdNone, fwdWb, fwdMem} fwdSelT; // operand source in execute

  typedef struct packed {
    logic  regWrite;  // result goes to the register file
    logic  memToReg;  // result comes from data memory
    logic  memWrite;
    logic  aluSrc;    // operand b is the immediate
    logic  regDst;    // destination is rd, else rt
    logic  branch;
    aluOpT aluOp;
  } ctrlT;

  typedef struct packed {
    ctrlT    ctrl;
    regAddrT rs;
    regAddrT rt;
    regAddrT rd;
    wordT    srcA;  // register values as read in decode
    wordT    srcB;
    wordT    imm;   // sign extended
  } deStageT;

  typedef struct packed {
    ctrlT    ctrl;
    regAddrT rs;
    regAddrT writeReg;   // rt for a store, which is also the store source
    wordT    aluOut;     // result or memory address
    wordT    writeData;  // store data
  } emStageT;

  typedef struct packed {
    logic    regWrite;
    logic    memToReg;
    regAddrT writeReg;
    wordT    aluOut;
    wordT    readData;
  } mwStageT;

endpackage

// ==== logic/regFile.sv ====
`timescale 1ns/1ps

module regFile (
  input  logic             clk,
  input  logic             arstN,
  input  mipsPkg::regAddrT ra1,
  input  mipsPkg::regAddrT ra2,
  output mipsPkg::wordT    rd1,
  output mipsPkg::wordT    rd2,
  input  logic             we,
  input  mipsPkg::regAddrT wa,
  input  mipsPkg::wordT    wd
);

  mipsPkg::wordT regs [32];

  // write in the first half, decode reads in the second half of the same cycle
  always_ff @(negedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (wa != mipsPkg::zeroReg)) begin
      regs[wa] <= wd;
    end
  end

  assign rd1 = (ra1 == mipsPkg::zeroReg) ? '0 : regs[ra1];  // $0 reads zero
  assign rd2 = (ra2 == mipsPkg::zeroReg) ? '0 : regs[ra2];

endmodule

// ==== logic/hazardUnit.sv ====
`timescale 1ns/1ps

module hazardUnit (
  input  logic             branchD,
  input  mipsPkg::regAddrT rsD,
  input  mipsPkg::regAddrT rtD,
  input  mipsPkg::regAddrT rsE,
  input  mipsPkg::regAddrT rtE,
  input  mipsPkg::regAddrT rtM,
  input  logic             memToRegE,
  input  logic             regWriteE,
  input  mipsPkg::regAddrT writeRegE,
  input  mipsPkg::regAddrT writeRegM,
  input  mipsPkg::regAddrT writeRegW,
  input  logic             memToRegM,
  input  logic             regWriteM,
  input  logic             regWriteW,
  input  logic             memWriteM,
  output logic             stallF,
  output logic             stallD,
  output logic             flushE,
  output logic             forwardAD,
  output logic             forwardBD,
  output logic             forwardMM,
  output mipsPkg::fwdSelT  forwardAE,
  output mipsPkg::fwdSelT  forwardBE
);

  logic lwStall;
  logic branchStall;
  logic stall;

  // a later stage writes the register a consumer reads, never $0
  function automatic logic hits(input mipsPkg::regAddrT src, input mipsPkg::regAddrT dst,
                                input logic wr);
    return wr && (src != mipsPkg::zeroReg) && (src == dst);
  endfunction

  // memory stage is younger than writeback so it wins
  assign forwardAE = hits(rsE, writeRegM, regWriteM) ? mipsPkg::fwdMem :
                     hits(rsE, writeRegW, regWriteW) ? mipsPkg::fwdWb : mipsPkg::fwdNone;
  assign forwardBE = hits(rtE, writeRegM, regWriteM) ? mipsPkg::fwdMem :
                     hits(rtE, writeRegW, regWriteW) ? mipsPkg::fwdWb : mipsPkg::fwdNone;

  assign forwardAD = hits(rsD, writeRegM, regWriteM);  // branch compare operands
  assign forwardBD = hits(rtD, writeRegM, regWriteM);

  // store right behind a load of its data register
  assign forwardMM = memWriteM && hits(rtM, writeRegW, regWriteW);

  assign lwStall = memToRegE && ((rtE == rsD) || (rtE == rtD));  // load data not ready yet

  // beq compares in decode, so results still in execute or a load in memory are too late
  assign branchStall = branchD &&
                       ((regWriteE && ((writeRegE == rsD) || (writeRegE == rtD))) ||
                        (memToRegM && ((writeRegM == rsD) || (writeRegM == rtD))));

  assign stall  = lwStall || branchStall;
  assign stallF = stall;
  assign stallD = stall;
  assign flushE = stall;  // bubble into execute while decode holds

endmodule

// ==== logic/decodeStage.sv ====
`timescale 1ns/1ps

module decodeStage (
  input  mipsPkg::wordT    instr,
  input  mipsPkg::addrT    pcPlus4,
  input  mipsPkg::wordT    rd1,
  input  mipsPkg::wordT    rd2,
  input  mipsPkg::wordT    aluOutM,
  input  logic             forwardAD,
  input  logic             forwardBD,
  output mipsPkg::ctrlT    ctrl,
  output mipsPkg::regAddrT rs,
  output mipsPkg::regAddrT rt,
  output mipsPkg::regAddrT rd,
  output mipsPkg::wordT    srcA,
  output mipsPkg::wordT    srcB,
  output mipsPkg::wordT    imm,
  output logic             pcSrc,
  output mipsPkg::addrT    pcBranch
);

  // instruction fields
  assign rs  = instr[25:21];
  assign rt  = instr[20:16];
  assign rd  = instr[15:11];
  assign imm = {{16{instr[15]}}, instr[15:0]};

  always_comb begin
    ctrl = '0;  // unknown encodings and the all-zero nop do nothing
    case (instr[31:26])
      mipsPkg::opRtype: begin
        ctrl.regWrite = 1'b1;
        ctrl.regDst   = 1'b1;
        case (instr[5:0])
          mipsPkg::fnAddu: ctrl.aluOp = mipsPkg::ADD;
          mipsPkg::fnSubu: ctrl.aluOp = mipsPkg::SUB;
          mipsPkg::fnAnd:  ctrl.aluOp = mipsPkg::AND;
          mipsPkg::fnOr:   ctrl.aluOp = mipsPkg::OR;
          mipsPkg::fnSlt:  ctrl.aluOp = mipsPkg::SLT;
          default:         ctrl       = '0;  // sll $0 etc, treated as nop
        endcase
      end
      mipsPkg::opLw: begin
        ctrl.regWrite = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.aluSrc   = 1'b1;  // base + offset
      end
      mipsPkg::opSw: begin
        ctrl.memWrite = 1'b1;
        ctrl.aluSrc   = 1'b1;
      end
      mipsPkg::opBeq: begin
        ctrl.branch = 1'b1;
        ctrl.aluOp  = mipsPkg::SUB;  // alu result unused, compare happens here
      end
      mipsPkg::opAddiu: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluSrc   = 1'b1;
      end
      default: ctrl = '0;
    endcase
  end

  // memory-stage result may be newer than the register file
  assign srcA = forwardAD ? aluOutM : rd1;
  assign srcB = forwardBD ? aluOutM : rd2;

  assign pcSrc    = ctrl.branch && (srcA == srcB);  // taken beq
  assign pcBranch = pcPlus4 + {imm[29:0], 2'b00};   // word offset to bytes

endmodule

// ==== logic/executeStage.sv ====
`timescale 1ns/1ps

module executeStage (
  input  mipsPkg::deStageT  de,
  input  mipsPkg::wordT     aluOutM,
  input  mipsPkg::wordT     resultW,
  input  mipsPkg::fwdSelT   forwardAE,
  input  mipsPkg::fwdSelT   forwardBE,
  output mipsPkg::emStageT  em,
  output mipsPkg::regAddrT  writeRegE
);

  mipsPkg::wordT srcA;
  mipsPkg::wordT srcBReg;  // rt value after forwarding, also the store data
  mipsPkg::wordT srcB;
  mipsPkg::wordT aluOut;

  // same mux for both operands
  function automatic mipsPkg::wordT pickSrc(input mipsPkg::fwdSelT sel,
                                            input mipsPkg::wordT regVal,
                                            input mipsPkg::wordT memVal,
                                            input mipsPkg::wordT wbVal);
    case (sel)
      mipsPkg::fwdMem: return memVal;
      mipsPkg::fwdWb:  return wbVal;
      default:         return regVal;
    endcase
  endfunction

  assign srcA    = pickSrc(forwardAE, de.srcA, aluOutM, resultW);
  assign srcBReg = pickSrc(forwardBE, de.srcB, aluOutM, resultW);
  assign srcB    = de.ctrl.aluSrc ? de.imm : srcBReg;  // immediate for addiu, lw, sw

  always_comb begin
    case (de.ctrl.aluOp)
      mipsPkg::ADD: aluOut = srcA + srcB;
      mipsPkg::SUB: aluOut = srcA - srcB;
      mipsPkg::AND: aluOut = srcA & srcB;
      mipsPkg::OR:  aluOut = srcA | srcB;
      mipsPkg::SLT: aluOut = {31'b0, $signed(srcA) < $signed(srcB)};  // signed compare
      default:      aluOut = '0;
    endcase
  end

  assign writeRegE = de.ctrl.regDst ? de.rd : de.rt;  // r-type uses rd

  always_comb begin
    em.ctrl      = de.ctrl;
    em.rs        = de.rs;
    em.writeReg  = writeRegE;
    em.aluOut    = aluOut;
    em.writeData = srcBReg;
  end

endmodule

// ==== logic/memoryStage.sv ====
`timescale 1ns/1ps

module memoryStage (
  input  logic              clk,
  input  logic              arstN,
  input  mipsPkg::emStageT  em,
  input  mipsPkg::wordT     resultW,
  input  logic              forwardMM,
  output mipsPkg::mwStageT  mw
);

  mipsPkg::wordT dmem [mipsPkg::dmemWords];
  logic [$clog2(mipsPkg::dmemWords)-1:0] wordIdx;
  mipsPkg::wordT storeData;

  assign wordIdx   = em.aluOut[$clog2(mipsPkg::dmemWords)+1:2];  // byte address to word
  assign storeData = forwardMM ? resultW : em.writeData;        // load result still in wb

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < mipsPkg::dmemWords; i++) begin
        dmem[i] <= '0;
      end
    end else if (em.ctrl.memWrite) begin
      dmem[wordIdx] <= storeData;
    end
  end

  always_comb begin
    mw.regWrite = em.ctrl.regWrite;
    mw.memToReg = em.ctrl.memToReg;
    mw.writeReg = em.writeReg;
    mw.aluOut   = em.aluOut;
    mw.readData = dmem[wordIdx];  // asynchronous read
  end

endmodule

// ==== logic/mipsCore.sv ====
`timescale 1ns/1ps

module mipsCore (
  input  logic             clk,
  input  logic             arstN,
  output mipsPkg::addrT    imemAddr,
  input  mipsPkg::wordT    imemData,
  output logic             wbValid,
  output mipsPkg::regAddrT wbReg,
  output mipsPkg::wordT    wbData
);

  typedef struct packed {
    mipsPkg::wordT instr;
    mipsPkg::addrT pcPlus4;
  } fdStageT;  // fetch to decode

  mipsPkg::addrT    pc;
  mipsPkg::addrT    pcPlus4F;
  fdStageT          fd;
  mipsPkg::deStageT de;
  mipsPkg::deStageT deNext;
  mipsPkg::emStageT em;
  mipsPkg::emStageT emNext;
  mipsPkg::mwStageT mw;
  mipsPkg::mwStageT mwNext;
  mipsPkg::ctrlT    ctrlD;
  mipsPkg::regAddrT rsD;
  mipsPkg::regAddrT rtD;
  mipsPkg::regAddrT rdD;
  mipsPkg::wordT    rd1D;
  mipsPkg::wordT    rd2D;
  mipsPkg::wordT    srcAD;
  mipsPkg::wordT    srcBD;
  mipsPkg::wordT    immD;
  logic             pcSrcD;
  mipsPkg::addrT    pcBranchD;
  mipsPkg::regAddrT writeRegE;
  mipsPkg::wordT    resultW;
  logic             stallF;
  logic             stallD;
  logic             flushD;
  logic             flushE;
  logic             forwardAD;
  logic             forwardBD;
  logic             forwardMM;
  mipsPkg::fwdSelT  forwardAE;
  mipsPkg::fwdSelT  forwardBE;

  // fetch
  assign imemAddr = pc;
  assign pcPlus4F = pc + 32'd4;
  assign flushD   = pcSrcD;  // squash the fall-through fetch, no delay slot

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pc <= '0;
    end else if (!stallF) begin
      pc <= pcSrcD ? pcBranchD : pcPlus4F;
    end
  end

  // pipeline registers, a stall outranks the branch squash
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      fd <= '0;
      de <= '0;
      em <= '0;
      mw <= '0;
    end else begin
      if (!stallD) begin
        fd <= flushD ? fdStageT'('0) : '{instr: imemData, pcPlus4: pcPlus4F};
      end
      de <= flushE ? mipsPkg::deStageT'('0) : deNext;  // bubble while decode waits
      em <= emNext;
      mw <= mwNext;
    end
  end

  regFile uRegFile (
    .clk(clk), .arstN(arstN),
    .ra1(rsD), .ra2(rtD), .rd1(rd1D), .rd2(rd2D),
    .we(mw.regWrite), .wa(mw.writeReg), .wd(resultW)
  );

  decodeStage uDecode (
    .instr(fd.instr), .pcPlus4(fd.pcPlus4),
    .rd1(rd1D), .rd2(rd2D), .aluOutM(em.aluOut),
    .forwardAD(forwardAD), .forwardBD(forwardBD),
    .ctrl(ctrlD), .rs(rsD), .rt(rtD), .rd(rdD),
    .srcA(srcAD), .srcB(srcBD), .imm(immD),
    .pcSrc(pcSrcD), .pcBranch(pcBranchD)
  );

  assign deNext = '{ctrl: ctrlD, rs: rsD, rt: rtD, rd: rdD,
                    srcA: srcAD, srcB: srcBD, imm: immD};

  hazardUnit uHazard (
    .branchD(ctrlD.branch), .rsD(rsD), .rtD(rtD),
    .rsE(de.rs), .rtE(de.rt), .rtM(em.writeReg),  // a store keeps rt in writeReg
    .memToRegE(de.ctrl.memToReg), .regWriteE(de.ctrl.regWrite),
    .writeRegE(writeRegE), .writeRegM(em.writeReg), .writeRegW(mw.writeReg),
    .memToRegM(em.ctrl.memToReg), .regWriteM(em.ctrl.regWrite),
    .regWriteW(mw.regWrite), .memWriteM(em.ctrl.memWrite),
    .stallF(stallF), .stallD(stallD), .flushE(flushE),
    .forwardAD(forwardAD), .forwardBD(forwardBD), .forwardMM(forwardMM),
    .forwardAE(forwardAE), .forwardBE(forwardBE)
  );

  executeStage uExecute (
    .de(de), .aluOutM(em.aluOut), .resultW(resultW),
    .forwardAE(forwardAE), .forwardBE(forwardBE),
    .em(emNext), .writeRegE(writeRegE)
  );

  memoryStage uMemory (
    .clk(clk), .arstN(arstN),
    .em(em), .resultW(resultW), .forwardMM(forwardMM), .mw(mwNext)
  );

  // writeback
  assign resultW = mw.memToReg ? mw.readData : mw.aluOut;
  assign wbValid = mw.regWrite && (mw.writeReg != mipsPkg::zeroReg);  // $0 writes are silent
  assign wbReg   = mw.writeReg;
  assign wbData  = resultW;

endmodule

// ==== verification/hazardChecker.sv ====
`timescale 1ns/1ps

module hazardChecker (
  input logic             clk,
  input logic             arstN,
  input logic             branchD,
  input mipsPkg::regAddrT rsE,
  input logic             memToRegE,
  input logic             stallF,
  input logic             stallD,
  input logic             flushE,
  input mipsPkg::fwdSelT  forwardAE
);

  logic loadStall;
  int   assertFails = 0;  // failed assertions so far

  assign loadStall = stallF && memToRegE && !branchD;  // load-use, no branch waiting in decode

  // one condition drives all three, and a stall needs a load in execute or a branch in decode
  stallsAgree: assert property (@(posedge clk) disable iff (!arstN)
    (stallF == stallD) && (stallD == flushE) && (!stallF || memToRegE || branchD))
    else begin
      $error("stall outputs differ or a stall has no cause");
      assertFails++;
    end

  noZeroForward: assert property (@(posedge clk) disable iff (!arstN)
    (rsE == mipsPkg::zeroReg) |-> (forwardAE != mipsPkg::fwdMem))
    else begin
      $error("forwardAE selects memory for $0");
      assertFails++;
    end

  // the flush leaves a bubble in execute, so the load has moved on
  singleLoadStall: assert property (@(posedge clk) disable iff (!arstN)
    loadStall |=> !loadStall)
    else begin
      $error("load-use stall held for two cycles");
      assertFails++;
    end

endmodule

// ==== verification/mipsCoreTb.sv ====
`timescale 1ns/1ps

module mipsCoreTb;

  localparam int numTests     = 5;
  localparam int clkPeriod    = 40;
  localparam int resetCycles  = 10;
  localparam int wbWaitCycles = 40;  // bound on the gap between two writebacks
  localparam int quietCycles  = 10;
  localparam int watchdogNs   = numTests * 64 * 3 * clkPeriod
                              + numTests * resetCycles * clkPeriod;

  logic             clk;
  logic             arstN;
  mipsPkg::addrT    imemAddr;
  mipsPkg::wordT    imemData;
  logic             wbValid;
  mipsPkg::regAddrT wbReg;
  mipsPkg::wordT    wbData;

  mipsPkg::wordT    imem [64];                     // instruction rom, word indexed
  mipsPkg::wordT    refRegs [32];                  // architectural model state
  mipsPkg::wordT    refMem [mipsPkg::dmemWords];
  mipsPkg::regAddrT expRegQ [$];                   // predicted writebacks in order
  mipsPkg::wordT    expDataQ [$];
  int               progLen;
  int               passCount;
  int               failCount;

  mipsCore DUT (
    .clk(clk), .arstN(arstN), .imemAddr(imemAddr), .imemData(imemData),
    .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
  );

  bind hazardUnit hazardChecker uHazardChk (
    .clk(mipsCoreTb.clk), .arstN(mipsCoreTb.arstN),
    .branchD(branchD), .rsE(rsE), .memToRegE(memToRegE),
    .stallF(stallF), .stallD(stallD), .flushE(flushE), .forwardAE(forwardAE)
  );

  // combinational read port, nop past the end of the rom
  assign imemData = (imemAddr[31:2] < 64) ? imem[imemAddr[7:2]] : '0;

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  function automatic mipsPkg::wordT rType(input logic [5:0] fn, input mipsPkg::regAddrT rd,
                                          input mipsPkg::regAddrT rs,
                                          input mipsPkg::regAddrT rt);
    return {mipsPkg::opRtype, rs, rt, rd, 5'd0, fn};
  endfunction

  // operand order as in assembly, rt first
  function automatic mipsPkg::wordT iType(input logic [5:0] op, input mipsPkg::regAddrT rt,
                                          input mipsPkg::regAddrT rs, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [15:0] randImm();
    return 16'($urandom());
  endfunction

  task automatic emit(input mipsPkg::wordT ins);
    imem[progLen] = ins;
    progLen++;
  endtask

  task automatic holdReset();
    @(posedge clk);
    arstN <= 1'b0;
    foreach (imem[i]) begin
      imem[i] = '0;  // all nop
    end
    progLen = 0;
  endtask

  task automatic setRef(input mipsPkg::regAddrT r, input mipsPkg::wordT v);
    if (r != mipsPkg::zeroReg) begin  // $0 stays zero and never shows at the port
      refRegs[r] = v;
      expRegQ.push_back(r);
      expDataQ.push_back(v);
    end
  endtask

  // runs the rom one instruction at a time, no pipeline
  task automatic predict();
    int            pcIdx;
    mipsPkg::wordT ins;
    mipsPkg::wordT a;
    mipsPkg::wordT b;
    mipsPkg::wordT imm;
    mipsPkg::wordT addr;
    expRegQ.delete();
    expDataQ.delete();
    foreach (refRegs[i]) begin
      refRegs[i] = '0;
    end
    foreach (refMem[i]) begin
      refMem[i] = '0;
    end
    pcIdx = 0;
    for (int step = 0; (step < 64) && (pcIdx >= 0) && (pcIdx < 64); step++) begin
      ins  = imem[pcIdx];
      a    = refRegs[ins[25:21]];
      b    = refRegs[ins[20:16]];
      imm  = {{16{ins[15]}}, ins[15:0]};
      addr = a + imm;
      pcIdx++;
      case (ins[31:26])
        mipsPkg::opRtype: begin
          case (ins[5:0])
            mipsPkg::fnAddu: setRef(ins[15:11], a + b);
            mipsPkg::fnSubu: setRef(ins[15:11], a - b);
            mipsPkg::fnAnd:  setRef(ins[15:11], a & b);
            mipsPkg::fnOr:   setRef(ins[15:11], a | b);
            mipsPkg::fnSlt:  setRef(ins[15:11], ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
            default: ;  // nop
          endcase
        end
        mipsPkg::opAddiu: setRef(ins[20:16], addr);
        mipsPkg::opLw:    setRef(ins[20:16], refMem[(addr >> 2) % mipsPkg::dmemWords]);
        mipsPkg::opSw:    refMem[(addr >> 2) % mipsPkg::dmemWords] = b;
        mipsPkg::opBeq: begin
          if (a == b) begin
            pcIdx = pcIdx + int'($signed(imm));  // relative to the next word
          end
        end
        default: ;
      endcase
    end
  endtask

  task automatic runProgram(input string name);
    int errs;
    int waited;
    errs = 0;
    predict();
    repeat (resetCycles) @(posedge clk);
    arstN <= 1'b1;
    while (expRegQ.size() > 0) begin
      waited = 0;
      do begin
        @(negedge clk);  // outputs settle between edges
        waited++;
      end while (!wbValid && (waited < wbWaitCycles));
      if (!wbValid) begin
        $display("%s: no writeback to $%0d within %0d cycles", name, expRegQ[0], wbWaitCycles);
        errs++;
        break;
      end
      if (wbReg !== expRegQ[0]) begin
        $display("ERROR at %0d ns: wbReg is %0d, expected %0d", $time, wbReg, expRegQ[0]);
        errs++;
      end
      if (wbData !== expDataQ[0]) begin
        $display("ERROR at %0d ns: wbData is %h, expected %h", $time, wbData, expDataQ[0]);
        errs++;
      end
      void'(expRegQ.pop_front());
      void'(expDataQ.pop_front());
    end
    repeat (quietCycles) begin  // squashed or $0 writes must stay silent
      @(negedge clk);
      if (wbValid) begin
        $display("%s: unexpected writeback to $%0d", name, wbReg);
        errs++;
      end
    end
    if (errs == 0) begin
      passCount++;
    end else begin
      failCount++;
    end
    $display("%-20s %s, %0d errors", name, (errs == 0) ? "ok" : "FAILED", errs);
  endtask

  task automatic forwardChainTest();
    holdReset();
    emit(iType(mipsPkg::opAddiu, 5'd1, mipsPkg::zeroReg, randImm()));
    emit(iType(mipsPkg::opAddiu, 5'd2, 5'd1, randImm()));  // memory to execute
    emit(rType(mipsPkg::fnAddu, 5'd3, 5'd2, 5'd1));        // memory and writeback
    emit(rType(mipsPkg::fnSubu, 5'd4, 5'd3, 5'd1));
    emit(rType(mipsPkg::fnAnd, 5'd5, 5'd4, 5'd3));
    emit(rType(mipsPkg::fnOr, 5'd6, 5'd5, 5'd2));
    emit(rType(mipsPkg::fnSlt, 5'd7, 5'd6, 5'd4));
    emit(rType(mipsPkg::fnAddu, 5'd8, 5'd7, 5'd6));
    runProgram("forward chain");
  endtask

  task automatic loadUseTest();
    holdReset();
    emit(iType(mipsPkg::opAddiu, 5'd1, mipsPkg::zeroReg, randImm()));
    emit(iType(mipsPkg::opSw, 5'd1, mipsPkg::zeroReg, 16'd12));
    emit(iType(mipsPkg::opLw, 5'd2, mipsPkg::zeroReg, 16'd12));
    emit(rType(mipsPkg::fnAddu, 5'd3, 5'd2, 5'd2));  // needs the stall
    emit(iType(mipsPkg::opLw, 5'd4, mipsPkg::zeroReg, 16'd12));
    emit(32'h0);
    emit(rType(mipsPkg::fnSubu, 5'd5, 5'd4, 5'd1));  // load value from writeback
    runProgram("load use");
  endtask

  task automatic branchTest();
    logic [15:0] v;
    holdReset();
    v = randImm();
    emit(iType(mipsPkg::opAddiu, 5'd1, mipsPkg::zeroReg, v));
    emit(iType(mipsPkg::opAddiu, 5'd2, mipsPkg::zeroReg, v));
    emit(iType(mipsPkg::opBeq, 5'd2, 5'd1, 16'd1));  // taken, operands one and two back
    emit(iType(mipsPkg::opAddiu, 5'd3, mipsPkg::zeroReg, 16'd1));  // squashed
    emit(iType(mipsPkg::opAddiu, 5'd4, mipsPkg::zeroReg, 16'd2));
    emit(iType(mipsPkg::opAddiu, 5'd5, 5'd4, 16'd1));
    emit(iType(mipsPkg::opBeq, 5'd4, 5'd5, 16'd1));  // not taken
    emit(iType(mipsPkg::opAddiu, 5'd6, mipsPkg::zeroReg, 16'd7));
    emit(iType(mipsPkg::opLw, 5'd7, mipsPkg::zeroReg, 16'd0));
    emit(iType(mipsPkg::opBeq, mipsPkg::zeroReg, 5'd7, 16'd1));  // load then compare
    emit(iType(mipsPkg::opAddiu, 5'd8, mipsPkg::zeroReg, 16'd9));
    emit(iType(mipsPkg::opAddiu, 5'd9, mipsPkg::zeroReg, 16'd10));
    runProgram("branch");
  endtask

  task automatic storeAfterLoadTest();
    holdReset();
    emit(iType(mipsPkg::opAddiu, 5'd3, mipsPkg::zeroReg, randImm()));
    emit(iType(mipsPkg::opSw, 5'd3, mipsPkg::zeroReg, 16'd0));
    emit(iType(mipsPkg::opLw, 5'd1, mipsPkg::zeroReg, 16'd0));
    emit(iType(mipsPkg::opSw, 5'd1, mipsPkg::zeroReg, 16'd8));  // store of the loaded word
    emit(iType(mipsPkg::opLw, 5'd2, mipsPkg::zeroReg, 16'd8));
    runProgram("store after load");
  endtask

  task automatic zeroRegTest();
    holdReset();
    emit(iType(mipsPkg::opAddiu, mipsPkg::zeroReg, mipsPkg::zeroReg, randImm()));
    emit(iType(mipsPkg::opAddiu, 5'd1, mipsPkg::zeroReg, randImm()));
    emit(rType(mipsPkg::fnAddu, mipsPkg::zeroReg, 5'd1, 5'd1));
    emit(rType(mipsPkg::fnAddu, 5'd2, mipsPkg::zeroReg, 5'd1));  // $0 sits in memory stage
    emit(rType(mipsPkg::fnOr, 5'd3, mipsPkg::zeroReg, mipsPkg::zeroReg));
    emit(iType(mipsPkg::opBeq, mipsPkg::zeroReg, mipsPkg::zeroReg, 16'd1));
    emit(iType(mipsPkg::opAddiu, 5'd4, mipsPkg::zeroReg, 16'd4));
    emit(iType(mipsPkg::opAddiu, 5'd5, mipsPkg::zeroReg, 16'd5));
    runProgram("zero register");
  endtask

  initial begin
    arstN     = 1'b0;
    progLen   = 0;
    passCount = 0;
    failCount = 0;
    foreach (imem[i]) begin
      imem[i] = '0;
    end
    void'($urandom(89));
    forwardChainTest();
    loadUseTest();
    branchTest();
    storeAfterLoadTest();
    zeroRegTest();
    $display("%0d tests ok, %0d tests failed, %0d assertion failures", passCount, failCount,
             DUT.uHazard.uHazardChk.assertFails);
    if ((failCount == 0) && (DUT.uHazard.uHazardChk.assertFails == 0)) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin
    #(watchdogNs);
    $display("watchdog expired after %0d ns, run did not finish", watchdogNs);
    $display("Test failures found");
    $finish;
  end

endmodule

// ==== filelist.f ====
logic/mipsPkg.sv
logic/regFile.sv
logic/hazardUnit.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/memoryStage.sv
logic/mipsCore.sv
verification/hazardChecker.sv
verification/mipsCoreTb.sv

// ==== Bender.yml ====
package:
  name: mipsCore

sources:
  - logic/mipsPkg.sv
  - logic/regFile.sv
  - logic/hazardUnit.sv
  - logic/decodeStage.sv
  - logic/executeStage.sv
  - logic/memoryStage.sv
  - logic/mipsCore.sv
  - target: test
    files:
      - verification/hazardChecker.sv
      - verification/mipsCoreTb.sv
